// File: source/id_pkg.sv
package id_pkg;

  ////////////////////////////////////////
  // widths

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int OP_W       = 6;   // primary opcode and function field
  localparam int IMM_W      = 16;
  localparam int JIDX_W     = 26;  // jump index of J and JAL

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // lsb of each instruction field
  localparam int OP_LSB = 26;
  localparam int RS_LSB = 21;
  localparam int RT_LSB = 16;
  localparam int RD_LSB = 11;
  localparam int SA_LSB = 6;

  localparam reg_addr_t REG_ZERO = 5'd0;
  localparam reg_addr_t REG_LINK = 5'd31;  // JAL and the linking branches

  localparam word_t PC_STEP = 32'd4;

  ////////////////////////////////////////
  // instruction codes

  localparam logic [OP_W-1:0] OPC_SPECIAL = 6'h00;
  localparam logic [OP_W-1:0] OPC_REGIMM  = 6'h01;
  localparam logic [OP_W-1:0] OPC_J       = 6'h02;
  localparam logic [OP_W-1:0] OPC_JAL     = 6'h03;
  localparam logic [OP_W-1:0] OPC_BEQ     = 6'h04;
  localparam logic [OP_W-1:0] OPC_BNE     = 6'h05;
  localparam logic [OP_W-1:0] OPC_BLEZ    = 6'h06;
  localparam logic [OP_W-1:0] OPC_BGTZ    = 6'h07;
  localparam logic [OP_W-1:0] OPC_ADDI    = 6'h08;
  localparam logic [OP_W-1:0] OPC_ADDIU   = 6'h09;
  localparam logic [OP_W-1:0] OPC_SLTI    = 6'h0a;
  localparam logic [OP_W-1:0] OPC_SLTIU   = 6'h0b;
  localparam logic [OP_W-1:0] OPC_ANDI    = 6'h0c;
  localparam logic [OP_W-1:0] OPC_ORI     = 6'h0d;
  localparam logic [OP_W-1:0] OPC_XORI    = 6'h0e;
  localparam logic [OP_W-1:0] OPC_LUI     = 6'h0f;

  localparam logic [OP_W-1:0] FN_SLL  = 6'h00;
  localparam logic [OP_W-1:0] FN_SRL  = 6'h02;
  localparam logic [OP_W-1:0] FN_SRA  = 6'h03;
  localparam logic [OP_W-1:0] FN_SLLV = 6'h04;
  localparam logic [OP_W-1:0] FN_SRLV = 6'h06;
  localparam logic [OP_W-1:0] FN_SRAV = 6'h07;
  localparam logic [OP_W-1:0] FN_JR   = 6'h08;
  localparam logic [OP_W-1:0] FN_JALR = 6'h09;
  localparam logic [OP_W-1:0] FN_ADD  = 6'h20;
  localparam logic [OP_W-1:0] FN_ADDU = 6'h21;
  localparam logic [OP_W-1:0] FN_SUB  = 6'h22;
  localparam logic [OP_W-1:0] FN_SUBU = 6'h23;
  localparam logic [OP_W-1:0] FN_AND  = 6'h24;
  localparam logic [OP_W-1:0] FN_OR   = 6'h25;
  localparam logic [OP_W-1:0] FN_XOR  = 6'h26;
  localparam logic [OP_W-1:0] FN_NOR  = 6'h27;
  localparam logic [OP_W-1:0] FN_SLT  = 6'h2a;
  localparam logic [OP_W-1:0] FN_SLTU = 6'h2b;

  // rt field selects the REGIMM branch
  localparam reg_addr_t RT_BLTZ   = 5'h00;
  localparam reg_addr_t RT_BGEZ   = 5'h01;
  localparam reg_addr_t RT_BLTZAL = 5'h10;
  localparam reg_addr_t RT_BGEZAL = 5'h11;

  typedef enum logic [4:0] {
    NOP, ADD, ADDU, SUB, SUBU, SLT, SLTU,
    AND, OR, XOR, NOR, LUI,
    SLL, SRL, SRA, SLLV, SRLV, SRAV,
    J, JAL, JR, JALR,
    BEQ, BNE, BGTZ, BLEZ, BLTZ, BGEZ, BLTZAL, BGEZAL
  } alu_op_e;

  typedef enum logic [2:0] {
    SEL_NOP,
    SEL_ARITH,
    SEL_LOGIC,
    SEL_SHIFT,
    SEL_JUMP    // branches too
  } alu_sel_e;

endpackage

// File: source/id_ifs.sv
// decoder results, shared by forwarding and branch logic
interface dec_if import id_pkg::*; ();
  alu_op_e   aluop;
  alu_sel_e  alusel;
  logic      reg1_read;
  logic      reg2_read;
  reg_addr_t reg1_addr;
  reg_addr_t reg2_addr;
  word_t     imm;
  logic      wreg;
  reg_addr_t wd;

  modport dec_mp (output aluop, alusel, reg1_read, reg2_read, reg1_addr, reg2_addr,
                  output imm, wreg, wd);
  modport use_mp (input aluop, alusel, reg1_read, reg2_read, reg1_addr, reg2_addr,
                  input imm, wreg, wd);
endinterface

// two dedicated read ports, data returns in the same cycle
interface rf_read_if import id_pkg::*; ();
  reg_addr_t raddr1;
  reg_addr_t raddr2;
  word_t     rdata1;
  word_t     rdata2;

  modport req_mp (output raddr1, raddr2, input rdata1, rdata2);
  modport rsp_mp (input raddr1, raddr2, output rdata1, rdata2);
endinterface

// File: source/inst_decoder.sv
module inst_decoder import id_pkg::*; (
  input  word_t inst_i,
  dec_if.dec_mp dec
);

  logic [OP_W-1:0]       op;
  logic [OP_W-1:0]       func;
  reg_addr_t             rs;
  reg_addr_t             rt;
  reg_addr_t             rd;
  logic [REG_ADDR_W-1:0] sa;
  logic [IMM_W-1:0]      imm16;
  logic                  is_imm;  // primary codes 0x08..0x0f
  alu_op_e               aluop;
  alu_sel_e              alusel;
  logic                  rd1;
  logic                  rd2;
  logic                  r1_rt;   // port 1 takes rt (shifts)
  logic                  r2_rs;   // port 2 takes rs (variable shifts)
  logic                  dst_rt;
  logic                  dst_rd;
  logic                  dst_link;

  assign op    = inst_i[OP_LSB +: OP_W];
  assign rs    = inst_i[RS_LSB +: REG_ADDR_W];
  assign rt    = inst_i[RT_LSB +: REG_ADDR_W];
  assign rd    = inst_i[RD_LSB +: REG_ADDR_W];
  assign sa    = inst_i[SA_LSB +: REG_ADDR_W];
  assign func  = inst_i[OP_W-1:0];
  assign imm16 = inst_i[IMM_W-1:0];

  assign is_imm = op inside {OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU,
                             OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI};

  ////////////////////////////////////////
  // classify

  always_comb begin
    aluop = NOP;  // anything unknown stays NOP
    case (op)
      OPC_SPECIAL: begin
        case (func)
          FN_SLL:  aluop = SLL;
          FN_SRL:  aluop = SRL;
          FN_SRA:  aluop = SRA;
          FN_SLLV: aluop = SLLV;
          FN_SRLV: aluop = SRLV;
          FN_SRAV: aluop = SRAV;
          FN_JR:   aluop = JR;
          FN_JALR: aluop = JALR;
          FN_ADD:  aluop = ADD;
          FN_ADDU: aluop = ADDU;
          FN_SUB:  aluop = SUB;
          FN_SUBU: aluop = SUBU;
          FN_AND:  aluop = AND;
          FN_OR:   aluop = OR;
          FN_XOR:  aluop = XOR;
          FN_NOR:  aluop = NOR;
          FN_SLT:  aluop = SLT;
          FN_SLTU: aluop = SLTU;
          default: aluop = NOP;
        endcase
      end
      OPC_REGIMM: begin
        case (rt)
          RT_BLTZ:   aluop = BLTZ;
          RT_BGEZ:   aluop = BGEZ;
          RT_BLTZAL: aluop = BLTZAL;
          RT_BGEZAL: aluop = BGEZAL;
          default:   aluop = NOP;
        endcase
      end
      OPC_J:     aluop = J;
      OPC_JAL:   aluop = JAL;
      OPC_BEQ:   aluop = BEQ;
      OPC_BNE:   aluop = BNE;
      OPC_BLEZ:  aluop = BLEZ;
      OPC_BGTZ:  aluop = BGTZ;
      OPC_ADDI:  aluop = ADD;   // immediate forms share the register opcode
      OPC_ADDIU: aluop = ADDU;
      OPC_SLTI:  aluop = SLT;
      OPC_SLTIU: aluop = SLTU;
      OPC_ANDI:  aluop = AND;
      OPC_ORI:   aluop = OR;
      OPC_XORI:  aluop = XOR;
      OPC_LUI:   aluop = LUI;
      default:   aluop = NOP;
    endcase
  end

  // unit, read ports and destination follow from the opcode
  always_comb begin
    alusel   = SEL_NOP;
    rd1      = 1'b0;
    rd2      = 1'b0;
    r1_rt    = 1'b0;
    r2_rs    = 1'b0;
    dst_rt   = 1'b0;
    dst_rd   = 1'b0;
    dst_link = 1'b0;
    case (aluop)
      ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR, LUI: begin
        alusel = (aluop inside {ADD, ADDU, SUB, SUBU, SLT, SLTU}) ? SEL_ARITH : SEL_LOGIC;
        rd1    = 1'b1;
        rd2    = !is_imm;  // immediate rides on port 2
        dst_rt = is_imm;
        dst_rd = !is_imm;
      end
      SLL, SRL, SRA, SLLV, SRLV, SRAV: begin
        alusel = SEL_SHIFT;
        rd1    = 1'b1;
        r1_rt  = 1'b1;
        rd2    = aluop inside {SLLV, SRLV, SRAV};
        r2_rs  = 1'b1;
        dst_rd = 1'b1;
      end
      J, JAL, JR, JALR, BEQ, BNE, BGTZ, BLEZ, BLTZ, BGEZ, BLTZAL, BGEZAL: begin
        alusel   = SEL_JUMP;
        rd1      = !(aluop inside {J, JAL});
        rd2      = aluop inside {BEQ, BNE};
        dst_rd   = aluop == JALR;
        dst_link = aluop inside {JAL, BLTZAL, BGEZAL};
      end
      default: alusel = SEL_NOP;
    endcase
  end

  always_comb begin
    dec.imm = '0;
    if (is_imm) begin
      case (aluop)
        LUI:          dec.imm = {imm16, {(XLEN-IMM_W){1'b0}}};
        AND, OR, XOR: dec.imm = {{(XLEN-IMM_W){1'b0}}, imm16};
        default:      dec.imm = {{(XLEN-IMM_W){imm16[IMM_W-1]}}, imm16};
      endcase
    end else if (aluop inside {SLL, SRL, SRA}) begin
      dec.imm = {{(XLEN-REG_ADDR_W){1'b0}}, sa};  // fixed shift amount
    end
  end

  assign dec.aluop     = aluop;
  assign dec.alusel    = alusel;
  assign dec.reg1_read = rd1;
  assign dec.reg2_read = rd2;
  assign dec.reg1_addr = !rd1 ? REG_ZERO : (r1_rt ? rt : rs);
  assign dec.reg2_addr = !rd2 ? REG_ZERO : (r2_rs ? rs : rt);
  assign dec.wreg      = dst_rt | dst_rd | dst_link;
  assign dec.wd        = dst_rt ? rt : dst_rd ? rd : dst_link ? REG_LINK : REG_ZERO;

  always_comb begin
    assert ($onehot0({dst_rt, dst_rd, dst_link}))
      else $error("more than one destination source selected");
  end

endmodule

// File: source/reg_file.sv
module reg_file import id_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i,
  rf_read_if.rsp_mp rd
);

  word_t regs [2**REG_ADDR_W];

  ////////////////////////////////////////
  // write port

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      regs <= '{default: '0};
    end else if (we_i && waddr_i != REG_ZERO) begin
      regs[waddr_i] <= wdata_i;  // r0 is dropped here
    end
  end

  ////////////////////////////////////////
  // read ports, no bypass from the write port

  // r0 stays at its reset value, so it reads zero
  assign rd.rdata1 = regs[rd.raddr1];
  assign rd.rdata2 = regs[rd.raddr2];

  // zero register holds across every write
  a_r0_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    regs[REG_ZERO] == '0)
    else $error("register 0 holds a nonzero value");

endmodule

// File: source/operand_forward.sv
module operand_forward import id_pkg::*; (
  dec_if.use_mp     dec,
  rf_read_if.req_mp rf,
  input  logic      ex_wreg_i,
  input  reg_addr_t ex_wd_i,
  input  word_t     ex_wdata_i,
  input  logic      mem_wreg_i,
  input  reg_addr_t mem_wd_i,
  input  word_t     mem_wdata_i,
  output word_t     reg1_o,
  output word_t     reg2_o
);

  // execute beats memory beats register file, r0 never forwards
  function automatic word_t pick_operand(input logic      rd_en,
                                         input reg_addr_t addr,
                                         input word_t     rf_data,
                                         input word_t     imm);
    if (!rd_en) begin
      return imm;
    end
    if (ex_wreg_i && ex_wd_i != REG_ZERO && ex_wd_i == addr) begin
      return ex_wdata_i;
    end
    if (mem_wreg_i && mem_wd_i != REG_ZERO && mem_wd_i == addr) begin
      return mem_wdata_i;
    end
    return rf_data;
  endfunction

  assign rf.raddr1 = dec.reg1_addr;  // already zero when not read
  assign rf.raddr2 = dec.reg2_addr;

  always_comb begin
    reg1_o = pick_operand(dec.reg1_read, dec.reg1_addr, rf.rdata1, dec.imm);
    reg2_o = pick_operand(dec.reg2_read, dec.reg2_addr, rf.rdata2, dec.imm);
  end

endmodule

// File: source/branch_unit.sv
module branch_unit import id_pkg::*; (
  input  word_t   pc_i,
  input  word_t   inst_i,
  input  alu_op_e aluop_i,
  input  word_t   reg1_i,
  input  word_t   reg2_i,
  output logic    branch_flag_o,
  output word_t   branch_addr_o,
  output word_t   link_addr_o,
  output logic    next_delay_o
);

  word_t pc_4;
  word_t pc_8;
  word_t jump_tgt;
  word_t br_tgt;
  logic  r1_neg;
  logic  r1_zero;
  logic  cond;       // conditional branch taken
  logic  is_branch;
  logic  is_jump;
  logic  links;

  assign pc_4     = pc_i + PC_STEP;
  assign pc_8     = pc_4 + PC_STEP;  // skips the delay slot
  assign jump_tgt = {pc_4[XLEN-1:JIDX_W+2], inst_i[JIDX_W-1:0], 2'b00};
  assign br_tgt   = pc_4 + {{(XLEN-IMM_W-2){inst_i[IMM_W-1]}}, inst_i[IMM_W-1:0], 2'b00};

  assign r1_neg  = reg1_i[XLEN-1];
  assign r1_zero = (reg1_i == '0);

  ////////////////////////////////////////
  // conditions on forwarded operands

  always_comb begin
    case (aluop_i)
      BEQ:          cond = (reg1_i == reg2_i);
      BNE:          cond = (reg1_i != reg2_i);
      BGTZ:         cond = !r1_neg && !r1_zero;
      BLEZ:         cond = r1_neg || r1_zero;
      BLTZ, BLTZAL: cond = r1_neg;
      BGEZ, BGEZAL: cond = !r1_neg;
      default:      cond = 1'b0;
    endcase
  end

  assign is_branch = aluop_i inside {BEQ, BNE, BGTZ, BLEZ, BLTZ, BGEZ, BLTZAL, BGEZAL};
  assign is_jump   = aluop_i inside {J, JAL, JR, JALR};
  assign links     = aluop_i inside {JAL, JALR, BLTZAL, BGEZAL};

  // delay slot follows every branch, taken or not
  assign next_delay_o  = is_branch | is_jump;
  assign branch_flag_o = is_jump | cond;

  always_comb begin
    case (aluop_i)
      J, JAL:  branch_addr_o = jump_tgt;
      JR, JALR: branch_addr_o = reg1_i;
      default: branch_addr_o = (is_branch && cond) ? br_tgt : '0;
    endcase
  end

  assign link_addr_o = links ? pc_8 : '0;

endmodule

// File: source/id_stage.sv
module id_stage import id_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  word_t     pc_i,
  input  word_t     inst_i,
  input  logic      in_delay_i,
  input  logic      ex_wreg_i,
  input  reg_addr_t ex_wd_i,
  input  word_t     ex_wdata_i,
  input  logic      mem_wreg_i,
  input  reg_addr_t mem_wd_i,
  input  word_t     mem_wdata_i,
  input  logic      wb_we_i,
  input  reg_addr_t wb_addr_i,
  input  word_t     wb_data_i,
  output alu_op_e   aluop_o,
  output alu_sel_e  alusel_o,
  output word_t     reg1_o,
  output word_t     reg2_o,
  output logic      wreg_o,
  output reg_addr_t wd_o,
  output logic      branch_flag_o,
  output word_t     branch_addr_o,
  output word_t     link_addr_o,
  output logic      next_delay_o,
  output logic      in_delay_o,
  output word_t     inst_o
);

  dec_if     dec_bus ();
  rf_read_if rf_bus ();

  word_t reg1_d;
  word_t reg2_d;
  logic  branch_flag_d;
  word_t branch_addr_d;
  word_t link_addr_d;
  logic  next_delay_d;

  inst_decoder u_decoder (
    .inst_i (inst_i),
    .dec    (dec_bus.dec_mp)
  );

  reg_file u_reg_file (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .we_i     (wb_we_i),
    .waddr_i  (wb_addr_i),
    .wdata_i  (wb_data_i),
    .rd       (rf_bus.rsp_mp)
  );

  operand_forward u_forward (
    .dec         (dec_bus.use_mp),
    .rf          (rf_bus.req_mp),
    .ex_wreg_i   (ex_wreg_i),
    .ex_wd_i     (ex_wd_i),
    .ex_wdata_i  (ex_wdata_i),
    .mem_wreg_i  (mem_wreg_i),
    .mem_wd_i    (mem_wd_i),
    .mem_wdata_i (mem_wdata_i),
    .reg1_o      (reg1_d),
    .reg2_o      (reg2_d)
  );

  branch_unit u_branch (
    .pc_i          (pc_i),
    .inst_i        (inst_i),
    .aluop_i       (dec_bus.aluop),
    .reg1_i        (reg1_d),
    .reg2_i        (reg2_d),
    .branch_flag_o (branch_flag_d),
    .branch_addr_o (branch_addr_d),
    .link_addr_o   (link_addr_d),
    .next_delay_o  (next_delay_d)
  );

  ////////////////////////////////////////
  // ID/EX register

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aluop_o       <= NOP;
      alusel_o      <= SEL_NOP;
      reg1_o        <= '0;
      reg2_o        <= '0;
      wreg_o        <= 1'b0;
      wd_o          <= REG_ZERO;
      branch_flag_o <= 1'b0;
      branch_addr_o <= '0;
      link_addr_o   <= '0;
      next_delay_o  <= 1'b0;
      in_delay_o    <= 1'b0;
      inst_o        <= '0;
    end else begin
      aluop_o       <= dec_bus.aluop;
      alusel_o      <= dec_bus.alusel;
      reg1_o        <= reg1_d;
      reg2_o        <= reg2_d;
      wreg_o        <= dec_bus.wreg;
      wd_o          <= dec_bus.wd;
      branch_flag_o <= branch_flag_d;
      branch_addr_o <= branch_addr_d;
      link_addr_o   <= link_addr_d;
      next_delay_o  <= next_delay_d;
      in_delay_o    <= in_delay_i;  // passed through for the next stage
      inst_o        <= inst_i;
    end
  end

  // a taken branch always opens a delay slot
  a_taken_has_slot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    branch_flag_o |-> next_delay_o)
    else $error("branch taken without delay slot");

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    arst_n_o <= 1'b1;  // released on a rising edge
  end

endmodule

// File: sim/tb_id_stage.sv
module tb_id_stage import id_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    CLK_PERIOD = 40;
  localparam int    RST_CYCLES = 8;
  localparam int    NCOL       = 19;  // columns of an I line
  localparam string GOLDEN     = "sim/id_golden.txt";

  logic clk, arst_n;
  word_t pc, inst, ex_wdata, mem_wdata, wb_data;
  logic in_delay, ex_wreg, mem_wreg, wb_we;
  reg_addr_t ex_wd, mem_wd, wb_addr;
  alu_op_e aluop_o;
  alu_sel_e alusel_o;
  word_t reg1_o, reg2_o, branch_addr_o, link_addr_o, inst_o;
  logic wreg_o, branch_flag_o, next_delay_o, in_delay_o;
  reg_addr_t wd_o;

  word_t cur [NCOL];
  word_t pend [NCOL];
  logic pend_valid;
  logic lines_counted;  // golden file length is known
  int n_lines;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) u_clk (
    .clk_o (clk), .arst_n_o (arst_n)
  );

  id_stage UUT (
    .clk_i (clk), .arst_n_i (arst_n), .pc_i (pc), .inst_i (inst), .in_delay_i (in_delay),
    .ex_wreg_i (ex_wreg), .ex_wd_i (ex_wd), .ex_wdata_i (ex_wdata),
    .mem_wreg_i (mem_wreg), .mem_wd_i (mem_wd), .mem_wdata_i (mem_wdata),
    .wb_we_i (wb_we), .wb_addr_i (wb_addr), .wb_data_i (wb_data),
    .aluop_o (aluop_o), .alusel_o (alusel_o), .reg1_o (reg1_o), .reg2_o (reg2_o),
    .wreg_o (wreg_o), .wd_o (wd_o), .branch_flag_o (branch_flag_o),
    .branch_addr_o (branch_addr_o), .link_addr_o (link_addr_o),
    .next_delay_o (next_delay_o), .in_delay_o (in_delay_o), .inst_o (inst_o)
  );

  task automatic fail_run();
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  ////////////////////////////////////////
  // compare tasks

  task automatic check_op(input string name, input alu_op_e exp, input alu_op_e act);
    if (exp !== act) begin
      $display("FAIL %s expected %h got %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_sel(input string name, input alu_sel_e exp, input alu_sel_e act);
    if (exp !== act) begin
      $display("FAIL %s expected %h got %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("FAIL %s expected %h got %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (exp !== act) begin
      $display("FAIL %s expected %h got %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAIL %s expected %h got %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_reset_values();
    check_op("aluop_o", NOP, aluop_o);
    check_sel("alusel_o", SEL_NOP, alusel_o);
    check_word("reg1_o", '0, reg1_o);
    check_word("reg2_o", '0, reg2_o);
    check_bit("wreg_o", 1'b0, wreg_o);
    check_addr("wd_o", REG_ZERO, wd_o);
    check_bit("branch_flag_o", 1'b0, branch_flag_o);
    check_word("branch_addr_o", '0, branch_addr_o);
    check_word("link_addr_o", '0, link_addr_o);
    check_bit("next_delay_o", 1'b0, next_delay_o);
    check_bit("in_delay_o", 1'b0, in_delay_o);
    check_word("inst_o", '0, inst_o);
  endtask

  // expected columns follow the nine input columns
  task automatic check_result();
    check_op("aluop_o", alu_op_e'(pend[9][4:0]), aluop_o);
    check_sel("alusel_o", alu_sel_e'(pend[10][2:0]), alusel_o);
    check_word("reg1_o", pend[11], reg1_o);
    check_word("reg2_o", pend[12], reg2_o);
    check_bit("wreg_o", pend[13][0], wreg_o);
    check_addr("wd_o", pend[14][4:0], wd_o);
    check_bit("branch_flag_o", pend[15][0], branch_flag_o);
    check_word("branch_addr_o", pend[16], branch_addr_o);
    check_word("link_addr_o", pend[17], link_addr_o);
    check_bit("next_delay_o", pend[18][0], next_delay_o);
    check_bit("in_delay_o", pend[2][0], in_delay_o);  // pass through
    check_word("inst_o", pend[1], inst_o);
  endtask

  task automatic drive_idle();
    pc <= '0;
    inst <= '0;
    in_delay <= 1'b0;
    ex_wreg <= 1'b0;
    ex_wd <= '0;
    ex_wdata <= '0;
    mem_wreg <= 1'b0;
    mem_wd <= '0;
    mem_wdata <= '0;
    wb_we <= 1'b0;
    wb_addr <= '0;
    wb_data <= '0;
  endtask

  ////////////////////////////////////////
  // watchdog

  initial begin
    wait (lines_counted);
    #(2 * (n_lines + RST_CYCLES) * CLK_PERIOD);
    $display("timeout: the test did not finish in the expected time");
    fail_run();
  end

  initial begin
    int fd;
    int code;
    string tag;
    string line_buf;
    pend_valid = 1'b0;
    lines_counted = 1'b0;
    n_lines = 0;
    drive_idle();
    fd = $fopen(GOLDEN, "r");
    if (fd == 0) begin
      $display("could not open the golden file %s", GOLDEN);
      fail_run();
    end
    while (!$feof(fd)) begin
      code = $fgets(line_buf, fd);
      if (code > 0) n_lines++;
    end
    $fclose(fd);
    lines_counted = 1'b1;
    fd = $fopen(GOLDEN, "r");

    @(negedge clk);
    check_reset_values();  // during reset
    wait (arst_n);
    @(negedge clk);
    check_reset_values();  // right after release

    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) break;
      if (tag == "#") begin
        code = $fgets(line_buf, fd);
        continue;
      end
      if (tag != "W" && tag != "I") begin
        $display("unknown line type %s in the golden file", tag);
        fail_run();
      end
      for (int i = 0; i < ((tag == "W") ? 2 : NCOL); i++) begin
        code = $fscanf(fd, "%h", cur[i]);
        if (code != 1) begin
          $display("malformed line in the golden file");
          fail_run();
        end
      end
      code = $fgets(line_buf, fd);  // trailing comment
      @(posedge clk);
      drive_idle();
      if (tag == "W") begin
        wb_we <= 1'b1;
        wb_addr <= cur[0][4:0];
        wb_data <= cur[1];
      end else begin
        pc <= cur[0];
        inst <= cur[1];
        in_delay <= cur[2][0];
        ex_wreg <= cur[3][0];
        ex_wd <= cur[4][4:0];
        ex_wdata <= cur[5];
        mem_wreg <= cur[6][0];
        mem_wd <= cur[7][4:0];
        mem_wdata <= cur[8];
      end
      @(negedge clk);
      if (pend_valid) check_result();  // previous line is now at the outputs
      pend_valid = (tag == "I");
      pend = cur;
    end
    $fclose(fd);
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    if (pend_valid) check_result();

    $display("All tests passed");
    $finish;
  end

endmodule

// File: sim/id_golden.txt
# W waddr wdata
# I pc inst dly exw exwd exdata memw memwd memdata | aluop sel reg1 reg2 wreg wd bflag baddr link ndly
W 01 00000005
W 02 fffffff0
W 03 00000005
I 00400000 00232020 0 0 00 00000000 0 00 00000000 01 1 00000005 00000005 1 04 0 00000000 00000000 0 # add
I 00400004 2045fffe 0 0 00 00000000 0 00 00000000 01 1 fffffff0 fffffffe 1 05 0 00000000 00000000 0 # addi
I 00400008 2c268000 0 0 00 00000000 0 00 00000000 06 1 00000005 ffff8000 1 06 0 00000000 00000000 0 # sltiu
I 0040000c 00413823 0 0 00 00000000 0 00 00000000 04 1 fffffff0 00000005 1 07 0 00000000 00000000 0 # subu
I 00400010 34288001 0 0 00 00000000 0 00 00000000 08 2 00000005 00008001 1 08 0 00000000 00000000 0 # ori
I 00400014 3c091234 0 0 00 00000000 0 00 00000000 0b 2 00000000 12340000 1 09 0 00000000 00000000 0 # lui
I 00400018 00225027 0 0 00 00000000 0 00 00000000 0a 2 00000005 fffffff0 1 0a 0 00000000 00000000 0 # nor
I 0040001c 00025900 0 0 00 00000000 0 00 00000000 0c 3 fffffff0 00000004 1 0b 0 00000000 00000000 0 # sll
I 00400020 00226007 0 0 00 00000000 0 00 00000000 11 3 fffffff0 00000005 1 0c 0 00000000 00000000 0 # srav
I 00400024 00216821 0 1 01 aaaa0001 1 01 bbbb0002 02 1 aaaa0001 aaaa0001 1 0d 0 00000000 00000000 0 # ex wins
I 00400028 00216821 0 0 01 aaaa0001 1 01 bbbb0002 02 1 bbbb0002 bbbb0002 1 0d 0 00000000 00000000 0 # mem
I 0040002c 00216821 0 1 02 aaaa0001 0 00 00000000 02 1 00000005 00000005 1 0d 0 00000000 00000000 0 # rf
I 00400030 00007020 0 1 00 11111111 1 00 22222222 01 1 00000000 00000000 1 0e 0 00000000 00000000 0 # r0
I 00400100 10230010 0 0 00 00000000 0 00 00000000 16 4 00000005 00000005 0 00 1 00400144 00000000 1 # beq t
I 00400100 10220010 1 0 00 00000000 0 00 00000000 16 4 00000005 fffffff0 0 00 0 00000000 00000000 1 # beq n
I 00400100 1422fffc 0 0 00 00000000 0 00 00000000 17 4 00000005 fffffff0 0 00 1 004000f4 00000000 1 # bne t
I 00400100 1423fffc 0 0 00 00000000 0 00 00000000 17 4 00000005 00000005 0 00 0 00000000 00000000 1 # bne n
I 00400100 1c200010 0 0 00 00000000 0 00 00000000 18 4 00000005 00000000 0 00 1 00400144 00000000 1 # bgtz t
I 00400100 1c400010 0 0 00 00000000 0 00 00000000 18 4 fffffff0 00000000 0 00 0 00000000 00000000 1 # bgtz n
I 00400100 18400010 0 0 00 00000000 0 00 00000000 19 4 fffffff0 00000000 0 00 1 00400144 00000000 1 # blez t
I 00400100 18200010 0 0 00 00000000 0 00 00000000 19 4 00000005 00000000 0 00 0 00000000 00000000 1 # blez n
I 00400100 04400010 0 0 00 00000000 0 00 00000000 1a 4 fffffff0 00000000 0 00 1 00400144 00000000 1 # bltz t
I 00400100 04200010 0 0 00 00000000 0 00 00000000 1a 4 00000005 00000000 0 00 0 00000000 00000000 1 # bltz n
I 00400100 04210010 0 0 00 00000000 0 00 00000000 1b 4 00000005 00000000 0 00 1 00400144 00000000 1 # bgez t
I 00400100 04410010 0 0 00 00000000 0 00 00000000 1b 4 fffffff0 00000000 0 00 0 00000000 00000000 1 # bgez n
I 00400100 04500010 1 0 00 00000000 0 00 00000000 1c 4 fffffff0 00000000 1 1f 1 00400144 00400108 1 # bltzal
I 00400100 04300010 0 0 00 00000000 0 00 00000000 1c 4 00000005 00000000 1 1f 0 00000000 00400108 1 # bltzal
I 00400100 04310010 0 0 00 00000000 0 00 00000000 1d 4 00000005 00000000 1 1f 1 00400144 00400108 1 # bgezal
I 00400100 04510010 0 0 00 00000000 0 00 00000000 1d 4 fffffff0 00000000 1 1f 0 00000000 00400108 1 # bgezal
I 00400100 08100040 0 0 00 00000000 0 00 00000000 12 4 00000000 00000000 0 00 1 00400100 00000000 1 # j
I 00400100 0c100040 0 0 00 00000000 0 00 00000000 13 4 00000000 00000000 1 1f 1 00400100 00400108 1 # jal
I 00400100 00600008 0 0 00 00000000 0 00 00000000 14 4 00000005 00000000 0 00 1 00000005 00000000 1 # jr
I 00400100 00208009 1 0 00 00000000 0 00 00000000 15 4 00000005 00000000 1 10 1 00000005 00400108 1 # jalr
I 00400200 8c240000 0 0 00 00000000 0 00 00000000 00 0 00000000 00000000 0 00 0 00000000 00000000 0 # lw

// File: all.f
source/id_pkg.sv
source/id_ifs.sv
source/inst_decoder.sv
source/reg_file.sv
source/operand_forward.sv
source/branch_unit.sv
source/id_stage.sv
sim/tb_clock_gen.sv
sim/tb_id_stage.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
TOP        := tb_id_stage
FILELIST   := all.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
